//--- source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // major opcodes
    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;

    // funct3 codes shared by both formats
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // one fetched word, seen as either format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } rv_inst_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

endpackage

`default_nettype wire

//--- source/ooo_cfg_pkg.sv
`default_nettype none

package ooo_cfg_pkg;

    localparam int XLEN       = 32;
    localparam int AREG_COUNT = 32;
    localparam int PRF_SIZE   = 64;
    localparam int ROB_TAG_W  = 5;  // room for 32 entries

    typedef logic [XLEN-1:0]               data_t;
    typedef logic [$clog2(AREG_COUNT)-1:0] areg_t;
    typedef logic [$clog2(PRF_SIZE)-1:0]   preg_t;
    typedef logic [ROB_TAG_W-1:0]          rob_tag_t;

    typedef struct packed {
        logic  ready;
        preg_t preg;  // producer tag while not ready
        data_t value;
    } operand_t;

    typedef struct packed {
        rv_isa_pkg::alu_op_e op;
        operand_t            opnd_a;
        operand_t            opnd_b;
        preg_t               dest;
        logic                we;
        rob_tag_t            tag;
    } issue_req_t;

    typedef struct packed {
        logic     valid;
        preg_t    preg;
        logic     we;    // low for x0 destinations
        rob_tag_t tag;
        data_t    value;
    } cdb_t;

    typedef struct packed {
        logic  valid;
        data_t pc;
        areg_t dest;
        data_t value;
        logic  illegal;
    } commit_t;

endpackage

`default_nettype wire

//--- source/rename_map.sv
`default_nettype none

module rename_map (
    input  wire logic               clock,
    input  wire logic               rst,
    input  wire logic               rename_en,
    input  ooo_cfg_pkg::areg_t      src_a,
    input  ooo_cfg_pkg::areg_t      src_b,
    input  ooo_cfg_pkg::areg_t      dest,
    output ooo_cfg_pkg::preg_t      src_a_preg,
    output ooo_cfg_pkg::preg_t      src_b_preg,
    output ooo_cfg_pkg::preg_t      new_preg,
    output ooo_cfg_pkg::preg_t      old_preg,
    output logic                    free_empty,
    input  wire logic               release_en,
    input  ooo_cfg_pkg::preg_t      release_preg
);

    // at most PRF_SIZE - AREG_COUNT registers are ever free
    localparam int FREE_DEPTH = ooo_cfg_pkg::PRF_SIZE - ooo_cfg_pkg::AREG_COUNT;
    localparam int FPTR_W     = $clog2(FREE_DEPTH);

    ooo_cfg_pkg::preg_t map_table [ooo_cfg_pkg::AREG_COUNT];
    ooo_cfg_pkg::preg_t free_fifo [FREE_DEPTH];
    logic [FPTR_W-1:0]  free_head;
    logic [FPTR_W-1:0]  free_tail;
    logic [FPTR_W:0]    free_count;
    logic               free_full;

    // lookups before this cycle's update
    assign src_a_preg = map_table[src_a];
    assign src_b_preg = map_table[src_b];
    assign old_preg   = map_table[dest];   // freed when this instr retires
    assign new_preg   = free_fifo[free_head];

    assign free_empty = (free_count == '0);
    assign free_full  = (free_count == (FPTR_W+1)'(FREE_DEPTH));

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < ooo_cfg_pkg::AREG_COUNT; i++) begin
                map_table[i] <= ooo_cfg_pkg::preg_t'(i);  // identity map
            end
            for (int i = 0; i < FREE_DEPTH; i++) begin
                free_fifo[i] <= ooo_cfg_pkg::preg_t'(ooo_cfg_pkg::AREG_COUNT + i);
            end
            free_head  <= '0;
            free_tail  <= '0;                        // wrapped, list is full
            free_count <= (FPTR_W+1)'(FREE_DEPTH);
        end else begin
            if (rename_en) begin
                map_table[dest] <= new_preg;
                free_head       <= free_head + 1'b1;  // pop
            end
            if (release_en) begin
                free_fifo[free_tail] <= release_preg;
                free_tail            <= free_tail + 1'b1;  // push
            end
            case ({rename_en, release_en})
                2'b10:   free_count <= free_count - 1'b1;
                2'b01:   free_count <= free_count + 1'b1;
                default: ;
            endcase
        end
    end

    // a retiring old register must always find room
    a_no_push_full: assert property (@(posedge clock) disable iff (rst)
        release_en |-> !free_full);

endmodule

`default_nettype wire

//--- source/phys_regfile.sv
`default_nettype none

module phys_regfile (
    input  wire logic               clock,
    input  wire logic               rst,
    input  ooo_cfg_pkg::preg_t      rd_a,
    input  ooo_cfg_pkg::preg_t      rd_b,
    output ooo_cfg_pkg::operand_t   opnd_a,
    output ooo_cfg_pkg::operand_t   opnd_b,
    input  wire logic               alloc_en,
    input  ooo_cfg_pkg::preg_t      alloc_preg,
    input  ooo_cfg_pkg::cdb_t       cdb
);

    ooo_cfg_pkg::data_t                 value_q [ooo_cfg_pkg::PRF_SIZE];
    logic [ooo_cfg_pkg::PRF_SIZE-1:0]   ready_q;
    logic                               cdb_wr;
    logic                               hit_a;
    logic                               hit_b;

    assign cdb_wr = cdb.valid && cdb.we;
    assign hit_a  = cdb_wr && (cdb.preg == rd_a);  // same cycle bypass
    assign hit_b  = cdb_wr && (cdb.preg == rd_b);

    always_comb begin
        opnd_a.preg  = rd_a;
        opnd_a.ready = hit_a || ready_q[rd_a];
        opnd_a.value = hit_a ? cdb.value : value_q[rd_a];
        opnd_b.preg  = rd_b;
        opnd_b.ready = hit_b || ready_q[rd_b];
        opnd_b.value = hit_b ? cdb.value : value_q[rd_b];
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < ooo_cfg_pkg::PRF_SIZE; i++) begin
                value_q[i] <= '0;
            end
            ready_q <= '1;  // everything readable as zero
        end else begin
            if (cdb_wr) begin
                value_q[cdb.preg] <= cdb.value;
                ready_q[cdb.preg] <= 1'b1;
            end
            if (alloc_en) begin
                ready_q[alloc_preg] <= 1'b0;  // pending until its result lands
            end
        end
    end

    // p0 backs x0 and must stay zero and ready
    a_p0_never_alloc: assert property (@(posedge clock) disable iff (rst)
        alloc_en |-> (alloc_preg != '0));

endmodule

`default_nettype wire

//--- source/alu_station.sv
`default_nettype none

module alu_station #(
    parameter int RS_DEPTH = 8
) (
    input  wire logic                   clock,
    input  wire logic                   rst,
    input  wire logic                   dispatch_en,
    input  ooo_cfg_pkg::issue_req_t     req,
    output logic                        full,
    output ooo_cfg_pkg::cdb_t           cdb
);

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    ooo_cfg_pkg::issue_req_t    entries [RS_DEPTH];
    logic [RS_DEPTH-1:0]        valid;
    logic [RS_DEPTH-1:0]        older_mask [RS_DEPTH];  // row i = entries older than i
    logic [RS_DEPTH-1:0]        rdy;
    logic [RS_DEPTH-1:0]        issue_sel;
    logic                       issue_any;
    logic [IDX_W-1:0]           issue_idx;
    logic [IDX_W-1:0]           free_idx;
    ooo_cfg_pkg::issue_req_t    req_woken;

    // capture a matching broadcast into a waiting operand
    function automatic ooo_cfg_pkg::operand_t wake(ooo_cfg_pkg::operand_t o,
                                                   ooo_cfg_pkg::cdb_t bus);
        ooo_cfg_pkg::operand_t r;
        r = o;
        if (!o.ready && bus.valid && bus.we && (bus.preg == o.preg)) begin
            r.ready = 1'b1;
            r.value = bus.value;
        end
        return r;
    endfunction

    function automatic ooo_cfg_pkg::data_t alu_exec(rv_isa_pkg::alu_op_e op,
                                                    ooo_cfg_pkg::data_t a,
                                                    ooo_cfg_pkg::data_t b);
        case (op)
            rv_isa_pkg::ALU_SUB:  return a - b;
            rv_isa_pkg::ALU_AND:  return a & b;
            rv_isa_pkg::ALU_OR:   return a | b;
            rv_isa_pkg::ALU_XOR:  return a ^ b;
            rv_isa_pkg::ALU_SLL:  return a << b[4:0];
            rv_isa_pkg::ALU_SRL:  return a >> b[4:0];
            rv_isa_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
            rv_isa_pkg::ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            rv_isa_pkg::ALU_SLTU: return {31'b0, a < b};
            default:              return a + b;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // select
    //////////////////////////////////////////////////

    always_comb begin
        issue_idx = '0;
        free_idx  = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            rdy[i] = valid[i] && entries[i].opnd_a.ready && entries[i].opnd_b.ready;
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            issue_sel[i] = rdy[i] && !(|(older_mask[i] & rdy));  // no older ready one
        end
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (issue_sel[i]) issue_idx = IDX_W'(i);
            if (!valid[i])    free_idx  = IDX_W'(i);   // lowest free slot
        end
        issue_any        = |rdy;
        req_woken        = req;
        req_woken.opnd_a = wake(req.opnd_a, cdb);
        req_woken.opnd_b = wake(req.opnd_b, cdb);
    end

    assign full = &valid;

    //////////////////////////////////////////////////
    // entry storage
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            entries[i].opnd_a <= wake(entries[i].opnd_a, cdb);
            entries[i].opnd_b <= wake(entries[i].opnd_b, cdb);
        end
        if (dispatch_en) entries[free_idx] <= req_woken;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            valid <= '0;
            for (int i = 0; i < RS_DEPTH; i++) older_mask[i] <= '0;
        end else begin
            valid <= valid & ~issue_sel;
            if (dispatch_en) begin
                valid[free_idx] <= 1'b1;
                for (int j = 0; j < RS_DEPTH; j++) begin
                    older_mask[j][free_idx] <= 1'b0;  // newcomer is younger than all
                end
                older_mask[free_idx] <= valid & ~issue_sel;
            end
        end
    end

    // single cycle alu, result register feeds the bus
    always_ff @(posedge clock) begin
        if (rst) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issue_any;
            cdb.preg  <= entries[issue_idx].dest;
            cdb.we    <= entries[issue_idx].we;
            cdb.tag   <= entries[issue_idx].tag;
            cdb.value <= alu_exec(entries[issue_idx].op,
                                  entries[issue_idx].opnd_a.value,
                                  entries[issue_idx].opnd_b.value);
        end
    end

    // top level must stall before the station overflows
    a_no_dispatch_full: assert property (@(posedge clock) disable iff (rst)
        dispatch_en |-> !full);

endmodule

`default_nettype wire

//--- source/reorder_buffer.sv
`default_nettype none

module reorder_buffer #(
    parameter int ROB_DEPTH = 16
) (
    input  wire logic               clock,
    input  wire logic               rst,
    input  wire logic               alloc_en,
    input  ooo_cfg_pkg::data_t      alloc_pc,
    input  ooo_cfg_pkg::areg_t      alloc_dest,
    input  ooo_cfg_pkg::preg_t      alloc_old_preg,
    input  wire logic               alloc_has_dest,
    input  wire logic               alloc_illegal,
    output ooo_cfg_pkg::rob_tag_t   tail_tag,
    output logic                    full,
    input  ooo_cfg_pkg::cdb_t       cdb,
    output ooo_cfg_pkg::commit_t    commit,
    output logic                    release_en,
    output ooo_cfg_pkg::preg_t      release_preg
);

    localparam int IDX_W = $clog2(ROB_DEPTH);

    typedef struct packed {
        ooo_cfg_pkg::data_t pc;
        ooo_cfg_pkg::areg_t dest;
        ooo_cfg_pkg::preg_t old_preg;
        logic               has_dest;
        logic               illegal;
        ooo_cfg_pkg::data_t value;
    } rob_entry_t;

    rob_entry_t             entries [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]   busy;
    logic [ROB_DEPTH-1:0]   done;
    logic [IDX_W-1:0]       head;
    logic [IDX_W-1:0]       tail;
    logic [IDX_W:0]         count;
    logic [IDX_W-1:0]       cdb_idx;

    assign cdb_idx  = cdb.tag[IDX_W-1:0];
    assign tail_tag = ooo_cfg_pkg::rob_tag_t'(tail);
    assign full     = (count == (IDX_W+1)'(ROB_DEPTH));

    always_comb begin
        commit.valid   = busy[head] && done[head];
        commit.pc      = entries[head].pc;
        commit.dest    = entries[head].dest;
        commit.value   = entries[head].has_dest ? entries[head].value : '0;  // x0 reads 0
        commit.illegal = entries[head].illegal;
    end

    assign release_en   = commit.valid && entries[head].has_dest;
    assign release_preg = entries[head].old_preg;

    always_ff @(posedge clock) begin
        if (alloc_en) begin
            entries[tail] <= '{alloc_pc, alloc_dest, alloc_old_preg,
                               alloc_has_dest, alloc_illegal, '0};
        end
        if (cdb.valid) entries[cdb_idx].value <= cdb.value;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            busy  <= '0;
            done  <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (commit.valid) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            if (alloc_en) begin
                busy[tail] <= 1'b1;
                done[tail] <= alloc_illegal;  // nothing to execute
                tail       <= tail + 1'b1;
            end
            if (cdb.valid) done[cdb_idx] <= 1'b1;
            case ({alloc_en, commit.valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // results only come back for live entries
    a_cdb_busy: assert property (@(posedge clock) disable iff (rst)
        cdb.valid |-> busy[cdb_idx]);

endmodule

`default_nettype wire

//--- source/ooo_core.sv
`default_nettype none

module ooo_core #(
    parameter int ROB_DEPTH = 16,
    parameter int RS_DEPTH  = 8
) (
    input  wire logic               clock,
    input  wire logic               rst,
    input  wire logic               inst_valid,
    input  rv_isa_pkg::rv_inst_u    inst,
    input  ooo_cfg_pkg::data_t      inst_pc,
    output logic                    dispatch_stall,
    output ooo_cfg_pkg::commit_t    commit
);

    rv_isa_pkg::alu_op_e        alu_op;
    ooo_cfg_pkg::data_t         imm;
    logic                       legal, is_imm, has_dest;
    logic                       dispatch, rename_en;
    logic                       rob_full, rs_full, free_empty;
    ooo_cfg_pkg::preg_t         src_a_preg, src_b_preg, new_preg, old_preg;
    ooo_cfg_pkg::operand_t      opnd_a, opnd_b;
    ooo_cfg_pkg::issue_req_t    req;
    ooo_cfg_pkg::rob_tag_t      tail_tag;
    ooo_cfg_pkg::cdb_t          cdb;
    logic                       release_en;
    ooo_cfg_pkg::preg_t         release_preg;

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////

    always_comb begin
        is_imm = (inst.r.opcode == rv_isa_pkg::OP_IMM);
        imm    = {{20{inst.i.imm[11]}}, inst.i.imm};  // sign extended I immediate
        case (inst.r.opcode)
            rv_isa_pkg::OP_REG: legal = (inst.r.funct7 == rv_isa_pkg::F7_BASE) ||
                                        ((inst.r.funct7 == rv_isa_pkg::F7_ALT) &&
                                         ((inst.r.funct3 == rv_isa_pkg::F3_ADD_SUB) ||
                                          (inst.r.funct3 == rv_isa_pkg::F3_SRL_SRA)));
            rv_isa_pkg::OP_IMM: begin
                // shift immediates reuse funct7 from the upper imm bits
                legal = 1'b1;
                if (inst.r.funct3 == rv_isa_pkg::F3_SLL)
                    legal = (inst.r.funct7 == rv_isa_pkg::F7_BASE);
                if (inst.r.funct3 == rv_isa_pkg::F3_SRL_SRA)
                    legal = (inst.r.funct7 == rv_isa_pkg::F7_BASE) ||
                            (inst.r.funct7 == rv_isa_pkg::F7_ALT);
            end
            default: legal = 1'b0;
        endcase
        case (inst.r.funct3)
            rv_isa_pkg::F3_ADD_SUB: alu_op = (!is_imm && inst.r.funct7 == rv_isa_pkg::F7_ALT) ?
                                             rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:     alu_op = rv_isa_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     alu_op = rv_isa_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    alu_op = rv_isa_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     alu_op = rv_isa_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: alu_op = (inst.r.funct7 == rv_isa_pkg::F7_ALT) ?
                                             rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      alu_op = rv_isa_pkg::ALU_OR;
            default:                alu_op = rv_isa_pkg::ALU_AND;
        endcase
    end

    // dispatch steering
    assign dispatch_stall = rob_full || rs_full || free_empty;
    assign dispatch       = inst_valid && !dispatch_stall;
    assign has_dest       = legal && (inst.r.rd != '0);  // x0 gets no register
    assign rename_en      = dispatch && has_dest;

    always_comb begin
        req.op     = alu_op;
        req.opnd_a = opnd_a;
        req.opnd_b = is_imm ? '{ready: 1'b1, preg: '0, value: imm} : opnd_b;
        req.dest   = has_dest ? new_preg : '0;
        req.we     = has_dest;
        req.tag    = tail_tag;
    end

    //////////////////////////////////////////////////
    // units
    //////////////////////////////////////////////////

    rename_map u_rename_map (
        .clock, .rst, .rename_en,
        .src_a(inst.r.rs1), .src_b(inst.r.rs2), .dest(inst.r.rd),
        .src_a_preg, .src_b_preg, .new_preg, .old_preg, .free_empty,
        .release_en, .release_preg
    );

    phys_regfile u_phys_regfile (
        .clock, .rst, .rd_a(src_a_preg), .rd_b(src_b_preg), .opnd_a, .opnd_b,
        .alloc_en(rename_en), .alloc_preg(new_preg), .cdb
    );

    alu_station #(.RS_DEPTH(RS_DEPTH)) u_alu_station (
        .clock, .rst, .dispatch_en(dispatch && legal), .req, .full(rs_full), .cdb
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_reorder_buffer (
        .clock, .rst, .alloc_en(dispatch), .alloc_pc(inst_pc), .alloc_dest(inst.r.rd),
        .alloc_old_preg(old_preg), .alloc_has_dest(has_dest), .alloc_illegal(!legal),
        .tail_tag, .full(rob_full), .cdb, .commit, .release_en, .release_preg
    );

endmodule

`default_nettype wire

//--- tb/ooo_core_tb.sv
`default_nettype none

module ooo_core_tb;

    localparam int N_MIX    = 160;
    localparam int N_X0     = 24;
    localparam int N_CHAIN  = 96;
    localparam int N_ILL    = 24;
    localparam int N_TOTAL  = N_MIX + N_X0 + N_CHAIN + N_ILL;
    localparam int WD_LIMIT = 40 * N_TOTAL + 100;  // watchdog, in cycles

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] word;
        logic        illegal;  // generated outside the supported set
    } sent_t;

    logic                   clock;
    logic                   rst;
    logic                   inst_valid;
    rv_isa_pkg::rv_inst_u   inst;
    ooo_cfg_pkg::data_t     inst_pc;
    logic                   dispatch_stall;
    ooo_cfg_pkg::commit_t   commit;

    sent_t                  exp_q [$];      // dispatched, not yet retired
    sent_t                  head_e;
    ooo_cfg_pkg::commit_t   exp_commit;     // valid means a head was there
    logic [31:0]            arf [32];       // reference register file
    logic [31:0]            rng;
    logic [31:0]            pc;
    logic                   dispatched_any;
    logic                   stall_seen;
    int                     dispatch_count;
    int                     commit_count;
    string                  test_name;

    ooo_core #(.ROB_DEPTH(16), .RS_DEPTH(8)) u_ooo_core (
        .clock, .rst, .inst_valid, .inst, .inst_pc, .dispatch_stall, .commit
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic report_fail(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic logic [31:0] reg_word(input int sel, input logic [4:0] rd, rs1, rs2);
        logic [9:0] f;  // {funct7, funct3}
        case (sel)
            0:       f = {7'h00, 3'd0};  // add
            1:       f = {7'h20, 3'd0};  // sub
            2:       f = {7'h00, 3'd7};  // and
            3:       f = {7'h00, 3'd6};  // or
            4:       f = {7'h00, 3'd4};  // xor
            5:       f = {7'h00, 3'd1};  // sll
            6:       f = {7'h00, 3'd5};  // srl
            7:       f = {7'h20, 3'd5};  // sra
            8:       f = {7'h00, 3'd2};  // slt
            default: f = {7'h00, 3'd3};  // sltu
        endcase
        return {f[9:3], rs2, rs1, f[2:0], rd, rv_isa_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] imm_word(input int sel, input logic [4:0] rd, rs1,
                                             input logic [11:0] imm);
        logic [11:0] v;
        logic [2:0]  f3;
        v = imm;
        case (sel)
            0: f3 = 3'd0;  // addi
            1: f3 = 3'd2;  // slti
            2: f3 = 3'd3;  // sltiu
            3: f3 = 3'd4;
            4: f3 = 3'd6;
            5: f3 = 3'd7;
            6: begin
                f3 = 3'd1;
                v  = {7'h00, imm[4:0]};  // slli
            end
            7: begin
                f3 = 3'd5;
                v  = {7'h00, imm[4:0]};  // srli
            end
            default: begin
                f3 = 3'd5;
                v  = {7'h20, imm[4:0]};  // srai
            end
        endcase
        return {v, rs1, f3, rd, rv_isa_pkg::OP_IMM};
    endfunction

    // a load opcode, or a multiply in the OP_REG space
    function automatic logic [31:0] bad_word(input logic [31:0] r);
        if (r[0]) return {r[31:7], 7'b0000011};
        return {7'b0000001, r[24:7], rv_isa_pkg::OP_REG};
    endfunction

    // rv32 result of one alu op
    function automatic logic [31:0] ref_result(input logic [31:0] w, a, rs2v);
        logic [31:0] b;
        b = (w[6:0] == rv_isa_pkg::OP_IMM) ? {{20{w[31]}}, w[31:20]} : rs2v;
        case (w[14:12])
            3'd0: return (w[6:0] == rv_isa_pkg::OP_REG && w[30]) ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (w[30]) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // called on a falling edge, returns on the one after acceptance
    task automatic send(input logic [31:0] word, input logic bad);
        sent_t s;
        inst_valid = 1'b1;
        inst       = word;
        inst_pc    = pc;
        while (dispatch_stall) begin  // hold the word
            stall_seen = 1'b1;
            @(negedge clock);
        end
        s.pc      = pc;
        s.word    = word;
        s.illegal = bad;
        exp_q.push_back(s);
        dispatched_any = 1'b1;
        dispatch_count++;
        pc = pc + 32'd4;
        @(negedge clock);
    endtask

    task automatic send_random(input int count, input logic [2:0] reg_mask, input int bad_one_in);
        logic [31:0] r;
        logic [4:0]  rd, rs1, rs2;
        for (int n = 0; n < count; n++) begin
            rng = xorshift32(rng);
            r   = rng;
            rd  = {2'b00, r[2:0] & reg_mask};  // small set forces deps
            rs1 = {2'b00, r[5:3] & reg_mask};
            rs2 = {2'b00, r[8:6] & reg_mask};
            if ((bad_one_in != 0) && (r[31:24] % bad_one_in == 0)) send(bad_word(r), 1'b1);
            else if (r[9]) send(reg_word(r[13:10] % 10, rd, rs1, rs2), 1'b0);
            else send(imm_word(r[13:10] % 9, rd, rs1, r[25:14]), 1'b0);
        end
    endtask

    // one serial chain through x3, the station backs up
    task automatic send_chain(input int count);
        logic [31:0] r;
        for (int n = 0; n < count; n++) begin
            rng = xorshift32(rng);
            r   = rng;
            if (r[9]) send(reg_word(r[13:10] % 10, 5'd3, 5'd3, 5'd3), 1'b0);
            else send(imm_word(r[13:10] % 9, 5'd3, 5'd3, r[25:14]), 1'b0);
        end
    endtask

    //////////////////////////////////////////////////
    // reference model and checks
    //////////////////////////////////////////////////

    // commit is stable here and retires at the next rising edge
    always @(negedge clock) begin
        if (!rst && commit.valid) begin
            commit_count++;  // every retirement the DUT shows
            exp_commit.valid = (exp_q.size() != 0);
            if (exp_q.size() != 0) begin
                head_e                = exp_q.pop_front();
                exp_commit.pc         = head_e.pc;
                exp_commit.dest       = head_e.word[11:7];
                exp_commit.illegal    = head_e.illegal;
                exp_commit.value      = '0;  // illegal and x0 carry zero
                if (!exp_commit.illegal && head_e.word[11:7] != 5'd0) begin
                    exp_commit.value = ref_result(head_e.word, arf[head_e.word[19:15]],
                                                  arf[head_e.word[24:20]]);
                    arf[head_e.word[11:7]] = exp_commit.value;
                end
            end
        end
    end

    a_quiet_after_reset: assert property (@(posedge clock) disable iff (rst)
        !dispatched_any |-> (!commit.valid && !dispatch_stall))
        else report_fail("commit or dispatch_stall went high before any dispatch");

    a_commit_known: assert property (@(posedge clock) disable iff (rst)
        commit.valid |-> exp_commit.valid)
        else report_fail("an instruction retired that was never dispatched");

    a_commit_pc: assert property (@(posedge clock) disable iff (rst)
        commit.valid |-> (commit.pc == exp_commit.pc))
        else report_fail($sformatf("ERR %s pc expected %h actual %h",
                                   test_name, exp_commit.pc, $sampled(commit.pc)));

    a_commit_dest: assert property (@(posedge clock) disable iff (rst)
        commit.valid |-> (commit.dest == exp_commit.dest))
        else report_fail($sformatf("ERR %s dest expected %0d actual %0d",
                                   test_name, exp_commit.dest, $sampled(commit.dest)));

    a_commit_value: assert property (@(posedge clock) disable iff (rst)
        commit.valid |-> (commit.value == exp_commit.value))
        else report_fail($sformatf("ERR %s value expected %h actual %h",
                                   test_name, exp_commit.value, $sampled(commit.value)));

    a_commit_illegal: assert property (@(posedge clock) disable iff (rst)
        commit.valid |-> (commit.illegal == exp_commit.illegal))
        else report_fail($sformatf("ERR %s illegal expected %b actual %b",
                                   test_name, exp_commit.illegal, $sampled(commit.illegal)));

    initial begin
        repeat (WD_LIMIT) @(posedge clock);
        report_fail("watchdog expired before every instruction retired");
    end

    initial begin
        rst            = 1'b1;
        inst_valid     = 1'b0;
        inst           = '0;
        inst_pc        = '0;
        rng            = 32'd33152;
        pc             = 32'h0000_1000;
        exp_commit     = '0;
        dispatched_any = 1'b0;
        stall_seen     = 1'b0;
        dispatch_count = 0;
        commit_count   = 0;
        test_name      = "reset";
        for (int i = 0; i < 32; i++) arf[i] = '0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        repeat (4) @(negedge clock);  // idle window after reset

        test_name = "random_mix";
        send_random(N_MIX, 3'b111, 16);
        test_name = "x0_writes";      // x0 and x1 only
        send_random(N_X0, 3'b001, 0);

        inst_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge clock);  // chains start on an empty core
        test_name  = "dep_chains";
        stall_seen = 1'b0;
        send_chain(N_CHAIN);
        a_stall_seen: assert (stall_seen)
            else report_fail("dispatch_stall never rose during the dependent chains");

        test_name = "illegal_ops";
        send_random(N_ILL, 3'b111, 3);

        inst_valid = 1'b0;
        test_name  = "drain";
        while (exp_q.size() != 0) @(negedge clock);
        repeat (8) @(negedge clock);  // a duplicate would trip a_commit_known

        a_counts_match: assert (commit_count == dispatch_count)
            else report_fail($sformatf("ERR drain commits expected %0d actual %0d",
                                       dispatch_count, commit_count));
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
source/rv_isa_pkg.sv
source/ooo_cfg_pkg.sv
source/rename_map.sv
source/phys_regfile.sv
source/alu_station.sv
source/reorder_buffer.sv
source/ooo_core.sv
tb/ooo_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ooo_core testbench with verilator, verdict from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=ooo_core_sim

verilator --binary --assert --timing -f src.f --top-module ooo_core_tb \
    -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation finished without failure"
exit 0
